// ==== project.f ====
rtl/ctx_pkg.sv
rtl/branch_predecode.sv
rtl/ctx_squash.sv
rtl/ctx_fork.sv
rtl/ctx_state.sv
rtl/ctx_manager.sv
dv/ctx_chk.sv
dv/ctx_monitor.sv
dv/ctx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ctx_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/ctx_tb.sv ====
module ctx_tb;
    import ctx_pkg::*;

    localparam int NUM_CTX = 8;
    localparam int TIMEOUT = 50;

    logic clk = 1'b0;
    logic arst_n;
    logic init;
    logic window_ready;
    logic fetch_req_valid;
    fetch_req_t fetch_req;
    logic fetch_done;
    logic [31:0] fetch_instr;
    logic dec_valid;
    dec_item_t dec_item;
    exec_res_t exec_res;
    logic branch_hazard;
    logic [NUM_CTX-1:0] hazard_kill;

    // reference model state
    int m_hot;
    int m_lp;
    logic [NUM_CTX-1:0] m_pend;
    logic [NUM_CTX-1:0] m_ks [NUM_CTX];
    pc_t m_pc [NUM_CTX];
    logic m_out;
    logic m_req_valid;
    int m_req_ctx;
    pc_t m_req_pc;

    fetch_req_t exp_req;
    dec_item_t exp_dec;
    logic exp_hazard;
    logic [NUM_CTX-1:0] exp_kill;
    int test_idx;
    logic test_end;
    int errors;
    int checks;
    logic [31:0] lfsr;

    always #10 clk = ~clk;

    ctx_manager #(.NUM_CTX(NUM_CTX)) uut (
        .clk(clk), .arst_n(arst_n), .init(init), .window_ready(window_ready),
        .fetch_req_valid(fetch_req_valid), .fetch_req(fetch_req),
        .fetch_done(fetch_done), .fetch_instr(fetch_instr),
        .dec_valid(dec_valid), .dec_item(dec_item), .exec_res(exec_res),
        .branch_hazard(branch_hazard), .hazard_kill(hazard_kill)
    );

    ctx_monitor #(.NUM_CTX(NUM_CTX)) u_mon (
        .clk(clk), .arst_n(arst_n), .fetch_req_valid(fetch_req_valid),
        .fetch_req(fetch_req), .dec_valid(dec_valid), .dec_item(dec_item),
        .branch_hazard(branch_hazard), .hazard_kill(hazard_kill),
        .exp_req_valid(m_req_valid), .exp_req(exp_req), .exp_dec_valid(fetch_done),
        .exp_dec(exp_dec), .exp_hazard(exp_hazard), .exp_kill(exp_kill),
        .test_idx(test_idx), .test_end(test_end), .errors(errors), .checks(checks)
    );

    bind ctx_manager ctx_chk u_chk (
        .clk(clk), .arst_n(arst_n), .fetch_req_valid(fetch_req_valid),
        .fetch_req(fetch_req), .dec_valid(dec_valid), .fetch_done(fetch_done)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] make_word(input instr_class_t c, input pc_t target);
        return {c, target[29:2], 2'b00};
    endfunction

    // program image, plain sequential words elsewhere
    function automatic logic [31:0] imem(input pc_t pc);
        case (pc)
            32'h0c: return make_word(CLS_JUMP, 32'h40);
            32'h40: return make_word(CLS_FORK, 32'h80);
            32'h80: return make_word(CLS_FORK, 32'hc0);
            32'hc0: return make_word(CLS_INDIRECT, 32'h0);
            default: return {2'b00, pc[29:0] ^ pc[31:2]};
        endcase
    endfunction

    function automatic int onehot_index(input logic [MAX_CTX-1:0] v);
        int idx;
        idx = 0;
        for (int i = 0; i < MAX_CTX; i++) begin
            if (v[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function void reset_model();
        m_hot = 0;
        m_lp = 0;
        m_pend = '0;
        m_pend[0] = 1'b1;
        for (int i = 0; i < NUM_CTX; i++) begin
            m_ks[i] = '0;
            m_pc[i] = '0;
        end
        m_out = 1'b0;
        m_req_valid = 1'b0;
    endfunction

    function void model_step(input logic ini, input logic wr, input logic done,
                             input logic [31:0] instr, input exec_res_t er);
        int old_hot;
        int t;
        int f;
        int j;
        logic [NUM_CTX-1:0] km;
        logic issue;
        pc_t tgt;
        old_hot = m_hot;
        km = '0;
        tgt = {2'b00, instr[29:2], 2'b00};
        if (ini) begin
            reset_model();
            return;
        end
        // squash the loser's kill set, hot moves to the survivor if hit
        if (er.valid && er.hazard) begin
            km = m_ks[onehot_index(er.hazard_ctx)];
            for (int i = 0; i < NUM_CTX; i++) begin
                m_ks[i] = km[i] ? '0 : (m_ks[i] & ~km);
                if (km[i]) begin
                    m_pend[i] = 1'b0;
                end
            end
            if (km[m_hot]) begin
                m_hot = onehot_index(er.safe_ctx);
            end
        end
        if (er.valid && er.jump_valid) begin
            j = onehot_index(er.jump_ctx);
            if (!km[j]) begin
                m_pc[j] = er.jump_pc;
                m_pend[j] = 1'b1;
            end
        end
        issue = wr && !m_out && m_pend[m_hot];
        if (issue) begin
            m_pend[m_hot] = 1'b0;
            m_req_ctx = m_hot;
            m_req_pc = m_pc[m_hot];
        end
        if (done) begin
            case (instr_class_t'(instr[31:30]))
                CLS_SEQ: begin
                    m_pc[old_hot] = m_req_pc + 32'd4;
                    m_pend[old_hot] = 1'b1;
                end
                CLS_JUMP: begin
                    m_pc[old_hot] = tgt;
                    m_pend[old_hot] = 1'b1;
                end
                CLS_FORK: begin
                    t = (m_lp + 1) % NUM_CTX;
                    f = (m_lp + 2) % NUM_CTX;
                    for (int i = 0; i < NUM_CTX; i++) begin
                        if (m_ks[i][old_hot]) begin
                            m_ks[i][t] = 1'b1;
                            m_ks[i][f] = 1'b1;
                        end
                    end
                    m_ks[t] = '0;
                    m_ks[t][t] = 1'b1;
                    m_ks[f] = '0;
                    m_ks[f][f] = 1'b1;
                    m_pend[t] = 1'b1;
                    m_pend[f] = 1'b1;
                    m_pc[t] = tgt;
                    m_pc[f] = m_req_pc + 32'd4;
                    m_hot = t;
                    m_lp = f;
                end
                default: begin
                end
            endcase
        end
        m_out = done ? 1'b0 : (issue ? 1'b1 : m_out);
        m_req_valid = issue;
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            reset_model();
            m_req_ctx = 0;
            m_req_pc = '0;
        end else begin
            model_step(init, window_ready, fetch_done, fetch_instr, exec_res);
        end
    end

    always_comb begin
        exp_req = '0;
        exp_req.ctx[m_req_ctx] = 1'b1;
        exp_req.pc = m_req_pc;
        exp_dec = '0;
        exp_dec.ctx[m_req_ctx] = 1'b1;
        exp_dec.pc = m_req_pc;
        exp_dec.cls = instr_class_t'(fetch_instr[31:30]);
        exp_dec.instr = fetch_instr;
        exp_hazard = exec_res.valid & exec_res.hazard;
        exp_kill = exp_hazard ? m_ks[onehot_index(exec_res.hazard_ctx)] : '0;
    end

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // answer one request after 1 to 4 cycles, optionally closing the window
    task automatic serve_fetch(input bit hold);
        int n;
        int lat;
        n = 0;
        @(posedge clk);
        while (!fetch_req_valid && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (!fetch_req_valid) begin
            stop_on_timeout("a fetch request");
        end else begin
            lat = 1;
            lfsr = lfsr_step(lfsr);
            lat += lfsr[0] ? 1 : 0;
            lfsr = lfsr_step(lfsr);
            lat += lfsr[0] ? 2 : 0;
            repeat (lat - 1) @(posedge clk);
            fetch_done <= 1'b1;
            fetch_instr <= imem(fetch_req.pc);
            @(posedge clk);
            fetch_done <= 1'b0;
            if (hold) begin
                window_ready <= 1'b0;
            end
        end
    endtask

    task automatic send_exec(input exec_res_t r);
        exec_res <= r;
        @(posedge clk);
        exec_res <= '0;
    endtask

    task automatic end_test();
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_idx <= test_idx + 1;
    endtask

    initial begin
        exec_res_t r;
        arst_n = 1'b0;
        init = 1'b0;
        window_ready = 1'b0;
        fetch_done = 1'b0;
        fetch_instr = '0;
        exec_res = '0;
        test_idx = 1;
        test_end = 1'b0;
        lfsr = 32'h5eca_2398;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        init <= 1'b1;
        @(posedge clk);
        init <= 1'b0;
        window_ready <= 1'b1;
        repeat (3) serve_fetch(1'b0);
        end_test();
        serve_fetch(1'b0);
        end_test();
        // two forks, then the indirect at the second taken target
        repeat (2) serve_fetch(1'b0);
        end_test();
        serve_fetch(1'b0);
        repeat (5) @(posedge clk);
        r = '0;
        r.valid = 1'b1;
        r.jump_valid = 1'b1;
        r.jump_ctx[3] = 1'b1;
        r.jump_pc = 32'h100;
        send_exec(r);
        serve_fetch(1'b1);
        end_test();
        repeat (6) @(posedge clk);
        window_ready <= 1'b1;
        serve_fetch(1'b1);
        end_test();
        r = '0;
        r.valid = 1'b1;
        r.hazard = 1'b1;
        r.hazard_ctx[1] = 1'b1;
        r.safe_ctx[2] = 1'b1;
        send_exec(r);
        window_ready <= 1'b1;
        serve_fetch(1'b0);
        end_test();
        repeat (3) @(posedge clk);
        $display("tests: 6, cycles checked: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.u_chk.fails);
        if (errors == 0 && uut.u_chk.fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/ctx_monitor.sv ====
module ctx_monitor #(
    parameter int NUM_CTX = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                fetch_req_valid,
    input  ctx_pkg::fetch_req_t fetch_req,
    input  logic                dec_valid,
    input  ctx_pkg::dec_item_t  dec_item,
    input  logic                branch_hazard,
    input  logic [NUM_CTX-1:0]  hazard_kill,
    input  logic                exp_req_valid,
    input  ctx_pkg::fetch_req_t exp_req,
    input  logic                exp_dec_valid,
    input  ctx_pkg::dec_item_t  exp_dec,
    input  logic                exp_hazard,
    input  logic [NUM_CTX-1:0]  exp_kill,
    input  int                  test_idx,
    input  logic                test_end,
    output int                  errors,
    output int                  checks
);
    import ctx_pkg::*;

    int test_errors;
    int test_checks;

    function automatic string test_name(input int idx);
        case (idx)
            1: return "sequential run in context 0";
            2: return "jump redirect";
            3: return "fork allocation";
            4: return "indirect stop and late jump";
            5: return "window back-pressure";
            6: return "hazard squash";
            default: return "unnamed";
        endcase
    endfunction

    initial begin
        errors = 0;
        checks = 0;
        test_errors = 0;
        test_checks = 0;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            test_checks++;
            checks++;
            if (fetch_req_valid !== exp_req_valid ||
                (exp_req_valid && fetch_req !== exp_req)) begin
                $display("error at %0t: fetch_req valid %b ctx %h pc %h, expected %b ctx %h pc %h",
                         $time, fetch_req_valid, fetch_req.ctx, fetch_req.pc,
                         exp_req_valid, exp_req.ctx, exp_req.pc);
                test_errors++;
                errors++;
            end
            if (dec_valid !== exp_dec_valid || (exp_dec_valid && dec_item !== exp_dec)) begin
                $display("error at %0t: dec_item ctx %h pc %h cls %0d, expected ctx %h pc %h cls %0d",
                         $time, dec_item.ctx, dec_item.pc, dec_item.cls,
                         exp_dec.ctx, exp_dec.pc, exp_dec.cls);
                test_errors++;
                errors++;
            end
            if (branch_hazard !== exp_hazard || (exp_hazard && hazard_kill !== exp_kill)) begin
                $display("error at %0t: branch_hazard %b kill %h, expected %b kill %h",
                         $time, branch_hazard, hazard_kill, exp_hazard, exp_kill);
                test_errors++;
                errors++;
            end
            if (test_end) begin
                $display("test %0d %s: %0d cycles checked, %0d errors, %s", test_idx,
                         test_name(test_idx), test_checks, test_errors,
                         (test_errors == 0) ? "pass" : "fail");
                test_errors = 0;
                test_checks = 0;
            end
        end
    end

endmodule

// ==== dv/ctx_chk.sv ====
module ctx_chk (
    input logic                clk,
    input logic                arst_n,
    input logic                fetch_req_valid,
    input ctx_pkg::fetch_req_t fetch_req,
    input logic                dec_valid,
    input logic                fetch_done
);
    import ctx_pkg::*;

    // running count of assertion failures
    int fails;

    initial begin
        fails = 0;
    end

    // request strobe is a single-cycle pulse
    a_req_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_req_valid |=> !fetch_req_valid)
        else begin
            $error("fetch_req_valid held for two cycles");
            fails++;
        end

    a_dec_with_done: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid |-> fetch_done)
        else begin
            $error("dec_valid without fetch_done");
            fails++;
        end

    a_req_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(fetch_req.ctx))
        else begin
            $error("fetch_req ctx is not one-hot");
            fails++;
        end

endmodule

// ==== rtl/ctx_manager.sv ====
module ctx_manager #(
    parameter int NUM_CTX = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 init,
    input  logic                 window_ready,
    output logic                 fetch_req_valid,
    output ctx_pkg::fetch_req_t  fetch_req,
    input  logic                 fetch_done,
    input  logic [31:0]          fetch_instr,
    output logic                 dec_valid,
    output ctx_pkg::dec_item_t   dec_item,
    input  ctx_pkg::exec_res_t   exec_res,
    output logic                 branch_hazard,
    output logic [NUM_CTX-1:0]   hazard_kill
);
    import ctx_pkg::*;

    // registered context state
    logic [NUM_CTX-1:0]              hot;
    logic [NUM_CTX-1:0]              last_publish;
    logic [NUM_CTX-1:0][NUM_CTX-1:0] kill_sets;
    pc_t                             cur_pc;

    // squash side
    logic [NUM_CTX-1:0] kill_mask;
    logic [NUM_CTX-1:0] squash_hot;
    logic               squash_take;
    logic               redirect_valid;
    logic [NUM_CTX-1:0] redirect_ctx;
    pc_t                redirect_pc;

    // fork side
    logic               fork_valid;
    logic [NUM_CTX-1:0] new_taken;
    logic [NUM_CTX-1:0] new_fall;
    logic               step_valid;
    pc_t                step_pc;
    pc_t                fall_pc;

    ctx_squash #(
        .NUM_CTX (NUM_CTX)
    ) u_squash (
        .exec_res       (exec_res),
        .hot            (hot),
        .kill_sets      (kill_sets),
        .kill_mask      (kill_mask),
        .squash_hot     (squash_hot),
        .squash_take    (squash_take),
        .redirect_valid (redirect_valid),
        .redirect_ctx   (redirect_ctx),
        .redirect_pc    (redirect_pc),
        .branch_hazard  (branch_hazard),
        .hazard_kill    (hazard_kill)
    );

    ctx_fork #(
        .NUM_CTX (NUM_CTX)
    ) u_fork (
        .fetch_done   (fetch_done),
        .fetch_instr  (fetch_instr),
        .cur_pc       (cur_pc),
        .hot          (hot),
        .last_publish (last_publish),
        .fork_valid   (fork_valid),
        .new_taken    (new_taken),
        .new_fall     (new_fall),
        .step_valid   (step_valid),
        .step_pc      (step_pc),
        .fall_pc      (fall_pc),
        .dec_valid    (dec_valid),
        .dec_item     (dec_item)
    );

    ctx_state #(
        .NUM_CTX (NUM_CTX)
    ) u_state (
        .clk             (clk),
        .arst_n          (arst_n),
        .init            (init),
        .window_ready    (window_ready),
        .fetch_done      (fetch_done),
        .kill_mask       (kill_mask),
        .squash_hot      (squash_hot),
        .squash_take     (squash_take),
        .redirect_valid  (redirect_valid),
        .redirect_ctx    (redirect_ctx),
        .redirect_pc     (redirect_pc),
        .fork_valid      (fork_valid),
        .new_taken       (new_taken),
        .new_fall        (new_fall),
        .step_valid      (step_valid),
        .step_pc         (step_pc),
        .fall_pc         (fall_pc),
        .hot             (hot),
        .last_publish    (last_publish),
        .kill_sets       (kill_sets),
        .cur_pc          (cur_pc),
        .outstanding     (),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req)
    );

endmodule

// ==== rtl/ctx_state.sv ====
module ctx_state #(
    parameter int NUM_CTX = 8
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               init,
    input  logic                               window_ready,
    input  logic                               fetch_done,
    input  logic [NUM_CTX-1:0]                 kill_mask,
    input  logic [NUM_CTX-1:0]                 squash_hot,
    input  logic                               squash_take,
    input  logic                               redirect_valid,
    input  logic [NUM_CTX-1:0]                 redirect_ctx,
    input  ctx_pkg::pc_t                       redirect_pc,
    input  logic                               fork_valid,
    input  logic [NUM_CTX-1:0]                 new_taken,
    input  logic [NUM_CTX-1:0]                 new_fall,
    input  logic                               step_valid,
    input  ctx_pkg::pc_t                       step_pc,
    input  ctx_pkg::pc_t                       fall_pc,
    output logic [NUM_CTX-1:0]                 hot,
    output logic [NUM_CTX-1:0]                 last_publish,
    output logic [NUM_CTX-1:0][NUM_CTX-1:0]    kill_sets,
    output ctx_pkg::pc_t                       cur_pc,
    output logic                               outstanding,
    output logic                               fetch_req_valid,
    output ctx_pkg::fetch_req_t                fetch_req
);
    import ctx_pkg::*;

    localparam logic [NUM_CTX-1:0] CTX0 = {{(NUM_CTX-1){1'b0}}, 1'b1};

    logic [NUM_CTX-1:0]              pending;
    pc_t [NUM_CTX-1:0]               next_pc;

    logic [NUM_CTX-1:0]              n_hot;
    logic [NUM_CTX-1:0]              n_lp;
    logic [NUM_CTX-1:0]              n_pending;
    logic [NUM_CTX-1:0][NUM_CTX-1:0] n_ks;
    pc_t [NUM_CTX-1:0]               n_pc;
    logic                            issue;
    pc_t                             issue_pc;

    always_comb begin
        n_hot = hot;
        n_lp = last_publish;
        n_pending = pending;
        n_ks = kill_sets;
        n_pc = next_pc;
        issue = 1'b0;
        issue_pc = '0;
        if (init) begin
            n_hot = CTX0;
            n_lp = CTX0;
            n_pending = CTX0;
            n_ks = '0;
            n_pc = '0;
        end else begin
            // squash and late jumps
            for (int i = 0; i < NUM_CTX; i++) begin
                if (kill_mask[i]) begin
                    n_ks[i] = '0;
                    n_pending[i] = 1'b0;
                end else begin
                    n_ks[i] = kill_sets[i] & ~kill_mask;
                end
                if (redirect_valid && redirect_ctx[i] && !kill_mask[i]) begin
                    n_pc[i] = redirect_pc;
                    n_pending[i] = 1'b1;
                end
            end
            if (squash_take) begin
                n_hot = squash_hot;
            end

            // request for whichever context is hot after the squash
            for (int i = 0; i < NUM_CTX; i++) begin
                if (n_hot[i]) begin
                    issue_pc = n_pc[i];
                end
            end
            issue = window_ready && !outstanding && (|(n_pending & n_hot));
            if (issue) begin
                n_pending = n_pending & ~n_hot;
            end

            // decode result, only while a fetch was outstanding
            if (step_valid) begin
                for (int i = 0; i < NUM_CTX; i++) begin
                    if (hot[i]) begin
                        n_pc[i] = step_pc;
                        n_pending[i] = 1'b1;
                    end
                end
            end
            if (fork_valid) begin
                // whoever would kill the parent also kills the children
                for (int i = 0; i < NUM_CTX; i++) begin
                    if (|(n_ks[i] & hot)) begin
                        n_ks[i] = n_ks[i] | new_taken | new_fall;
                    end
                end
                for (int i = 0; i < NUM_CTX; i++) begin
                    if (new_taken[i] || new_fall[i]) begin
                        n_ks[i] = CTX0 << i;
                        n_pending[i] = 1'b1;
                        n_pc[i] = new_taken[i] ? step_pc : fall_pc;
                    end
                end
                n_hot = new_taken;
                n_lp = new_fall;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hot <= CTX0;
            last_publish <= CTX0;
            pending <= CTX0;
            kill_sets <= '0;
            next_pc <= '0;
            outstanding <= 1'b0;
            fetch_req_valid <= 1'b0;
            fetch_req.ctx <= '0;
            fetch_req.ctx[0] <= 1'b1;
            fetch_req.pc <= '0;
        end else begin
            hot <= n_hot;
            last_publish <= n_lp;
            pending <= n_pending;
            kill_sets <= n_ks;
            next_pc <= n_pc;
            fetch_req_valid <= issue;
            if (init || fetch_done) begin
                outstanding <= 1'b0;
            end else if (issue) begin
                outstanding <= 1'b1;
            end
            if (issue) begin
                fetch_req.ctx <= '0;
                fetch_req.ctx[NUM_CTX-1:0] <= n_hot;
                fetch_req.pc <= issue_pc;
            end
        end
    end

    // pc of the fetch in flight
    assign cur_pc = fetch_req.pc;

endmodule

// ==== rtl/ctx_fork.sv ====
module ctx_fork #(
    parameter int NUM_CTX = 8
) (
    input  logic                 fetch_done,
    input  logic [31:0]          fetch_instr,
    input  ctx_pkg::pc_t         cur_pc,
    input  logic [NUM_CTX-1:0]   hot,
    input  logic [NUM_CTX-1:0]   last_publish,
    output logic                 fork_valid,
    output logic [NUM_CTX-1:0]   new_taken,
    output logic [NUM_CTX-1:0]   new_fall,
    output logic                 step_valid,
    output ctx_pkg::pc_t         step_pc,
    output ctx_pkg::pc_t         fall_pc,
    output logic                 dec_valid,
    output ctx_pkg::dec_item_t   dec_item
);
    import ctx_pkg::*;

    instr_class_t cls;
    pc_t          pd_next_pc;
    pc_t          pd_alt_pc;

    branch_predecode u_predecode (
        .instr   (fetch_instr),
        .pc      (cur_pc),
        .cls     (cls),
        .next_pc (pd_next_pc),
        .alt_pc  (pd_alt_pc)
    );

    // fresh contexts come from the publish rotation
    assign new_taken = {last_publish[NUM_CTX-2:0], last_publish[NUM_CTX-1]};
    assign new_fall  = {last_publish[NUM_CTX-3:0], last_publish[NUM_CTX-1:NUM_CTX-2]};

    // seq and jump keep the same context
    assign step_valid = fetch_done & ((cls == CLS_SEQ) | (cls == CLS_JUMP));
    assign fork_valid = fetch_done & (cls == CLS_FORK);

    // taken side of a fork uses the same target as a step
    assign step_pc = pd_next_pc;
    assign fall_pc = pd_alt_pc;

    // indirect raises neither, hot stays idle until execute answers

    assign dec_valid = fetch_done;

    always_comb begin
        dec_item = '0;
        dec_item.ctx[NUM_CTX-1:0] = hot;
        dec_item.pc = cur_pc;
        dec_item.cls = cls;
        dec_item.instr = fetch_instr;
    end

endmodule

// ==== rtl/ctx_squash.sv ====
module ctx_squash #(
    parameter int NUM_CTX = 8
) (
    input  ctx_pkg::exec_res_t                 exec_res,
    input  logic [NUM_CTX-1:0]                 hot,
    input  logic [NUM_CTX-1:0][NUM_CTX-1:0]    kill_sets,
    output logic [NUM_CTX-1:0]                 kill_mask,
    output logic [NUM_CTX-1:0]                 squash_hot,
    output logic                               squash_take,
    output logic                               redirect_valid,
    output logic [NUM_CTX-1:0]                 redirect_ctx,
    output ctx_pkg::pc_t                       redirect_pc,
    output logic                               branch_hazard,
    output logic [NUM_CTX-1:0]                 hazard_kill
);
    localparam int IDX_W = $clog2(NUM_CTX);

    logic [IDX_W-1:0]   haz_idx;
    logic [NUM_CTX-1:0] haz_set;
    logic               squash_en;

    // one-hot losing context to an index
    always_comb begin
        haz_idx = '0;
        for (int i = 0; i < NUM_CTX; i++) begin
            if (exec_res.hazard_ctx[i]) begin
                haz_idx = IDX_W'(i);
            end
        end
    end

    assign haz_set   = kill_sets[haz_idx];
    assign squash_en = exec_res.valid & exec_res.hazard;

    // everything the loser would have spawned goes away
    assign kill_mask = squash_en ? haz_set : '0;

    // hot only moves if it was among the killed
    assign squash_take = |(kill_mask & hot);
    assign squash_hot  = exec_res.safe_ctx[NUM_CTX-1:0];

    // late target for an indirect
    assign redirect_valid = exec_res.valid & exec_res.jump_valid;
    assign redirect_ctx   = exec_res.jump_ctx[NUM_CTX-1:0];
    assign redirect_pc    = exec_res.jump_pc;

    assign branch_hazard = squash_en;
    assign hazard_kill   = kill_mask;

endmodule

// ==== rtl/branch_predecode.sv ====
module branch_predecode (
    input  logic [31:0]          instr,
    input  ctx_pkg::pc_t         pc,
    output ctx_pkg::instr_class_t cls,
    output ctx_pkg::pc_t         next_pc,
    output ctx_pkg::pc_t         alt_pc
);
    import ctx_pkg::*;

    pc_t seq_pc;
    pc_t target_pc;

    assign cls = instr_class_t'(instr[31:30]);

    assign seq_pc = pc + 32'd4;

    // absolute word target from bits 29:2
    assign target_pc = {2'b00, instr[29:2], 2'b00};

    always_comb begin
        case (cls)
            CLS_SEQ: begin
                next_pc = seq_pc;
            end
            CLS_JUMP, CLS_FORK: begin
                next_pc = target_pc;
            end
            default: begin
                // indirect, execute supplies the target later
                next_pc = pc;
            end
        endcase
    end

    // fall-through side of a fork
    assign alt_pc = seq_pc;

endmodule

// ==== rtl/ctx_pkg.sv ====
package ctx_pkg;

    // widest context field carried in any struct
    localparam int MAX_CTX = 16;

    typedef logic [31:0] pc_t;

    // class lives in instr[31:30]
    typedef enum logic [1:0] {
        CLS_SEQ      = 2'b00,
        CLS_JUMP     = 2'b01,
        CLS_FORK     = 2'b10,
        CLS_INDIRECT = 2'b11
    } instr_class_t;

    // resolution from execute, valid is the strobe
    typedef struct packed {
        logic               valid;
        logic               hazard;
        logic [MAX_CTX-1:0] hazard_ctx;
        logic [MAX_CTX-1:0] safe_ctx;
        logic               jump_valid;
        logic [MAX_CTX-1:0] jump_ctx;
        pc_t                jump_pc;
    } exec_res_t;

    // request towards the instruction cache
    typedef struct packed {
        logic [MAX_CTX-1:0] ctx;
        pc_t                pc;
    } fetch_req_t;

    // predecoded item for the instruction window
    typedef struct packed {
        logic [MAX_CTX-1:0] ctx;
        pc_t                pc;
        instr_class_t       cls;
        logic [31:0]        instr;
    } dec_item_t;

endpackage
